// File: compile.f
logic/sounder_pkg.sv
logic/config_reg.sv
logic/pn_lfsr.sv
logic/sounder_ctrl.sv
logic/sounder_tx.sv
logic/sounder_rx.sv
logic/sounder.sv
testbench/sounder_properties.sv
testbench/sounder_tb.sv

// File: testbench/sounder_tb.sv
// Channel sounder testbench
// Table-driven run through transmit, loopback and external receive modes,
// checked against a PN reference model, with a watchdog on the whole run
`timescale 1ns/1ps

module sounder_tb;

   localparam int clk_period = 4;
   localparam int num_rows   = 7;

   typedef struct packed {
      logic [4:0]  degree;
      logic [3:0]  mode;    // Loopback, receive, transmit, reset
      logic [15:0] adc_i;
      logic [15:0] adc_q;
      logic [7:0]  sweeps;
      logic [7:0]  extra;   // Partial sweep, dropped by the next restart
   } row_t;

   localparam row_t rows [0:num_rows-1] = '{
      '{5'd3, 4'b0010, 16'h0000, 16'h0000, 8'd2,  8'd3},   // Tx only
      '{5'd5, 4'b0010, 16'h0000, 16'h0000, 8'd2,  8'd0},
      '{5'd7, 4'b0010, 16'h0000, 16'h0000, 8'd1,  8'd20},
      '{5'd3, 4'b1110, 16'h0000, 16'h0000, 8'd7,  8'd2},   // Loopback, every lag
      '{5'd4, 4'b1110, 16'h0000, 16'h0000, 8'd15, 8'd4},
      '{5'd5, 4'b0100, 16'h0123, 16'hFF00, 8'd4,  8'd10},  // External receive
      '{5'd0, 4'b0110, 16'h7FFF, 16'h8000, 8'd3,  8'd1}    // Degree clamps to 2
   };

   logic        clk_i;
   logic        rst_n_i;
   logic [6:0]  saddr_i;
   logic [31:0] sdata_i;
   logic        s_strobe_i;
   logic        tx_strobe_i;
   logic        rx_strobe_i;
   logic [15:0] rx_adc_i_i, rx_adc_q_i;
   logic [13:0] tx_dac_i_o, tx_dac_q_o;
   logic        rx_strobe_o;
   logic [15:0] rx_imp_i_o, rx_imp_q_o;

   logic [15:0]        tx_st, rx_st, mask;   // Model LFSR states
   logic signed [13:0] m_tx_i, m_tx_q;       // Model Tx registers
   logic               loop, tx_en, rx_en;
   int                 acc_i, acc_q, count, len, deg, peak_i;
   int                 errors = 0;
   logic [13:0]        hist [$];             // Expected I chips of this row
   logic [15:0]        held_i, held_q;       // Last expected impulse sample
   logic               held_valid = 1'b0;

   sounder uut (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .saddr_i     (saddr_i),
      .sdata_i     (sdata_i),
      .s_strobe_i  (s_strobe_i),
      .tx_strobe_i (tx_strobe_i),
      .rx_strobe_i (rx_strobe_i),
      .rx_adc_i_i  (rx_adc_i_i),
      .rx_adc_q_i  (rx_adc_q_i),
      .tx_dac_i_o  (tx_dac_i_o),
      .tx_dac_q_o  (tx_dac_q_o),
      .rx_strobe_o (rx_strobe_o),
      .rx_imp_i_o  (rx_imp_i_o),
      .rx_imp_q_o  (rx_imp_q_o)
   );

   always #(clk_period / 2) clk_i = ~clk_i;

   function automatic int clamp_degree(input int d);
      if (d < sounder_pkg::min_degree) return sounder_pkg::min_degree;
      if (d > sounder_pkg::max_degree) return sounder_pkg::max_degree;
      return d;
   endfunction

   // Shift right, fold the mask in when a one drops out
   function automatic logic [15:0] pn_advance(input logic [15:0] st, input logic [15:0] m);
      logic [15:0] nxt;
      nxt = st >> 1;
      if (st[0]) nxt = nxt ^ m;
      return nxt;
   endfunction

   function automatic logic [13:0] dac_expect(input logic signed [13:0] v);
      return loop ? 14'd0 : v;   // Muted in loopback
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
   endtask

   task automatic report_text(input string what);
      $display("%s at %0t", what, $time);
      errors++;
   endtask

   task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
      saddr_i    <= addr;
      sdata_i    <= data;
      s_strobe_i <= 1'b1;
      @(posedge clk_i);   // Register takes the write here
      s_strobe_i <= 1'b0;
   endtask

   // Mirror one chip in the model and compare, called after the strobe edge
   task automatic step_model();
      int          in_i, in_q;
      logic        pulse;
      logic [15:0] exp_imp_i, exp_imp_q;
      if (loop) begin   // Rx sees the Tx registers from before this strobe
         in_i = int'(m_tx_i);
         in_q = int'(m_tx_q);
      end else begin
         in_i = int'($signed(rx_adc_i_i));
         in_q = int'($signed(rx_adc_q_i));
      end
      if (tx_en) begin
         m_tx_q = m_tx_i;   // Q one chip behind
         m_tx_i = tx_st[0] ? sounder_pkg::dac_pos : sounder_pkg::dac_neg;
         tx_st  = pn_advance(tx_st, mask);
      end
      pulse = 1'b0;
      if (rx_en) begin
         acc_i += rx_st[0] ? in_i : -in_i;
         acc_q += rx_st[0] ? in_q : -in_q;
         count++;
         if (count == len) begin   // Sweep complete, reference stays put
            pulse     = 1'b1;
            exp_imp_i = 16'(acc_i >>> deg);
            exp_imp_q = 16'(acc_q >>> deg);
            acc_i     = 0;
            acc_q     = 0;
            count     = 0;
         end else begin
            rx_st = pn_advance(rx_st, mask);
         end
      end
      if (tx_dac_i_o !== dac_expect(m_tx_i)) begin
         report_value("tx_dac_i_o", tx_dac_i_o, dac_expect(m_tx_i));
      end
      if (tx_dac_q_o !== dac_expect(m_tx_q)) begin
         report_value("tx_dac_q_o", tx_dac_q_o, dac_expect(m_tx_q));
      end
      if (tx_en && !loop) begin   // Period of the sequence
         if (hist.size() >= len && tx_dac_i_o !== hist[hist.size() - len]) begin
            report_value("tx_dac_i_o period", tx_dac_i_o, hist[hist.size() - len]);
         end
         hist.push_back(m_tx_i);
      end
      if (pulse && rx_strobe_o !== 1'b1) report_text("Missing rx_strobe_o after a full sweep");
      else if (rx_strobe_o !== pulse) report_value("rx_strobe_o", rx_strobe_o, pulse);
      if (pulse) begin
         if (rx_imp_i_o !== exp_imp_i) report_value("rx_imp_i_o", rx_imp_i_o, exp_imp_i);
         if (rx_imp_q_o !== exp_imp_q) report_value("rx_imp_q_o", rx_imp_q_o, exp_imp_q);
         if ($signed(rx_imp_i_o) > peak_i) peak_i = $signed(rx_imp_i_o);
         held_i     = exp_imp_i;
         held_q     = exp_imp_q;
         held_valid = 1'b1;
      end else if (held_valid) begin   // Impulse outputs hold between sweep ends
         if (rx_imp_i_o !== held_i) report_value("rx_imp_i_o", rx_imp_i_o, held_i);
         if (rx_imp_q_o !== held_q) report_value("rx_imp_q_o", rx_imp_q_o, held_q);
      end
   endtask

   task automatic send_chip();
      int idle;
      idle = $urandom_range(1, 4);   // Idle cycles before the next chip
      tx_strobe_i <= 1'b1;
      rx_strobe_i <= 1'b1;
      @(posedge clk_i);
      tx_strobe_i <= 1'b0;
      rx_strobe_i <= 1'b0;
      @(negedge clk_i);
      step_model();
      repeat (idle - 1) begin   // Quiet cycles, outputs must hold
         @(negedge clk_i);
         if (rx_strobe_o !== 1'b0) report_text("rx_strobe_o high between sweep ends");
         if (tx_dac_i_o !== dac_expect(m_tx_i)) begin
            report_value("tx_dac_i_o", tx_dac_i_o, dac_expect(m_tx_i));
         end
         if (tx_dac_q_o !== dac_expect(m_tx_q)) begin
            report_value("tx_dac_q_o", tx_dac_q_o, dac_expect(m_tx_q));
         end
      end
      @(posedge clk_i);
   endtask

   task automatic run_row(input row_t row);
      int total;
      int peak_exp;
      deg    = clamp_degree(row.degree);
      len    = (1 << deg) - 1;
      mask   = sounder_pkg::pn_mask_table[deg];
      loop   = row.mode[3];
      rx_en  = row.mode[2];
      tx_en  = row.mode[1];
      tx_st  = 16'd1;   // Both sequences restart from the seed
      rx_st  = 16'd1;
      m_tx_i = '0;
      m_tx_q = '0;
      acc_i  = 0;
      acc_q  = 0;
      count  = 0;
      peak_i = -65536;
      hist.delete();
      rx_adc_i_i <= row.adc_i;
      rx_adc_q_i <= row.adc_q;
      bus_write(sounder_pkg::degree_addr, 32'(row.degree));
      bus_write(sounder_pkg::mode_addr, 32'(row.mode | 4'b0001));   // Restart
      bus_write(sounder_pkg::mode_addr, 32'(row.mode));
      total = row.sweeps * len + row.extra;
      for (int k = 0; k < total; k++) send_chip();
      peak_exp = (len * int'(sounder_pkg::dac_pos)) >>> deg;   // Aligned lag
      if (loop && rx_en && tx_en && peak_i != peak_exp) begin
         report_value("rx_imp_i_o peak", peak_i, peak_exp);
      end
   endtask

   initial begin : stimulus
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      saddr_i     = '0;
      sdata_i     = '0;
      s_strobe_i  = 1'b0;
      tx_strobe_i = 1'b0;
      rx_strobe_i = 1'b0;
      rx_adc_i_i  = '0;
      rx_adc_q_i  = '0;
      void'($urandom(30587));
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (int r = 0; r < num_rows; r++) run_row(rows[r]);
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Limit from the chip count of every row, at most 6 cycles per chip
   initial begin : watchdog
      longint cycles;
      int     d;
      cycles = 100;
      for (int r = 0; r < num_rows; r++) begin
         d = clamp_degree(rows[r].degree);
         cycles += (rows[r].sweeps * ((1 << d) - 1) + rows[r].extra) * 6 + 20;
      end
      #(cycles * clk_period);
      $display("Watchdog expired after %0d cycles, run did not complete", cycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: testbench/sounder_properties.sv
// Sounder properties
// Strobe framing, loopback muting and DAC update timing, bound into the top
`timescale 1ns/1ps

module sounder_properties (
   input logic                             clk_i,
   input logic                             rst_n_i,
   input logic                             seq_rst_i,
   input logic                             loop_i,
   input logic                             rx_ena_i,
   input logic                             tx_strobe_i,
   input logic                             pulse_i,    // Impulse sample strobe
   input logic [sounder_pkg::dac_width-1:0] dac_i_i,
   input logic [sounder_pkg::dac_width-1:0] dac_q_i
);

   a_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pulse_i |=> !pulse_i)
      else $error("rx_strobe_o high for two cycles");

   // Pulse set at an edge where the receiver was enabled
   a_pulse_enabled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(pulse_i) |-> $past(rx_ena_i))
      else $error("rx_strobe_o rose with receive disabled");

   a_loop_mute: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      loop_i |-> (dac_i_i == '0 && dac_q_i == '0))
      else $error("DAC not zero in loopback");

   // Only a chip strobe, a restart or a loopback change moves the DAC
   a_dac_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!$past(tx_strobe_i) && !$past(seq_rst_i) && $stable(loop_i))
         |-> ($stable(dac_i_i) && $stable(dac_q_i)))
      else $error("DAC changed without a tx strobe");

endmodule

bind sounder sounder_properties u_props (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .seq_rst_i   (seq_rst),
   .loop_i      (loop),
   .rx_ena_i    (rx_ena),
   .tx_strobe_i (tx_strobe_i),
   .pulse_i     (rx_strobe_o),
   .dac_i_i     (tx_dac_i_o),
   .dac_q_i     (tx_dac_q_o)
);

// File: logic/sounder.sv
// Direct-sequence channel sounder, top level
// Configuration registers drive a PN transmitter and a sliding correlator.
// In loopback the DAC is muted and the receiver listens to the
// transmitter's own samples instead of the ADC
`timescale 1ns/1ps

module sounder (
   input  logic                                clk_i,        // Board master clock
   input  logic                                rst_n_i,
   input  logic [sounder_pkg::saddr_width-1:0]  saddr_i,      // Configuration bus
   input  logic [sounder_pkg::sdata_width-1:0]  sdata_i,
   input  logic                                s_strobe_i,
   input  logic                                tx_strobe_i,  // Next Tx chip
   input  logic                                rx_strobe_i,  // ADC sample valid
   input  logic [sounder_pkg::sample_width-1:0] rx_adc_i_i,
   input  logic [sounder_pkg::sample_width-1:0] rx_adc_q_i,
   output logic [sounder_pkg::dac_width-1:0]    tx_dac_i_o,
   output logic [sounder_pkg::dac_width-1:0]    tx_dac_q_o,
   output logic                                rx_strobe_o,  // Impulse sample ready
   output logic [sounder_pkg::sample_width-1:0] rx_imp_i_o,
   output logic [sounder_pkg::sample_width-1:0] rx_imp_q_o
);

   localparam int ext_width = sounder_pkg::sample_width - sounder_pkg::dac_width;

   logic                                seq_rst;
   logic                                tx_ena;
   logic                                rx_ena;
   logic                                loop;
   logic [sounder_pkg::degree_width-1:0] degree;
   logic [sounder_pkg::pn_width-1:0]     mask;
   logic [sounder_pkg::pn_width-1:0]     len;
   logic [sounder_pkg::dac_width-1:0]    tx_i, tx_q;     // Transmitter registers
   logic [sounder_pkg::sample_width-1:0] rx_i, rx_q;     // Correlator input

   sounder_ctrl u_ctrl (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .s_strobe_i (s_strobe_i),
      .saddr_i    (saddr_i),
      .sdata_i    (sdata_i),
      .seq_rst_o  (seq_rst),
      .tx_ena_o   (tx_ena),
      .rx_ena_o   (rx_ena),
      .loop_o     (loop),
      .degree_o   (degree),
      .mask_o     (mask),
      .len_o      (len)
   );

   sounder_tx u_tx (
      .clk_i    (clk_i),
      .clr_i    (seq_rst),
      .ena_i    (tx_ena),
      .strobe_i (tx_strobe_i),
      .mask_i   (mask),
      .tx_i_o   (tx_i),
      .tx_q_o   (tx_q)
   );

   // Loopback, DAC silent and Rx fed from the sign-extended Tx registers
   assign tx_dac_i_o = loop ? '0 : tx_i;
   assign tx_dac_q_o = loop ? '0 : tx_q;
   assign rx_i = loop ? {{ext_width{tx_i[sounder_pkg::dac_width-1]}}, tx_i} : rx_adc_i_i;
   assign rx_q = loop ? {{ext_width{tx_q[sounder_pkg::dac_width-1]}}, tx_q} : rx_adc_q_i;

   sounder_rx u_rx (
      .clk_i       (clk_i),
      .clr_i       (seq_rst),
      .ena_i       (rx_ena),
      .rx_strobe_i (rx_strobe_i),
      .mask_i      (mask),
      .degree_i    (degree),
      .len_i       (len),
      .rx_in_i_i   (rx_i),
      .rx_in_q_i   (rx_q),
      .rx_strobe_o (rx_strobe_o),
      .rx_i_o      (rx_imp_i_o),
      .rx_q_o      (rx_imp_q_o)
   );

endmodule

// File: logic/sounder_rx.sv
// Sounder receiver
// Correlates received I/Q samples against a local PN copy over one full
// sequence. Each completed sweep yields one impulse-response sample,
// scaled down by the degree. The local sequence slips one chip per sweep
// so successive outputs walk through every lag
`timescale 1ns/1ps

module sounder_rx (
   input  logic                                clk_i,
   input  logic                                clr_i,
   input  logic                                ena_i,
   input  logic                                rx_strobe_i,  // Input sample valid
   input  logic [sounder_pkg::pn_width-1:0]     mask_i,
   input  logic [sounder_pkg::degree_width-1:0] degree_i,
   input  logic [sounder_pkg::pn_width-1:0]     len_i,        // Samples per sweep
   input  logic [sounder_pkg::sample_width-1:0] rx_in_i_i,
   input  logic [sounder_pkg::sample_width-1:0] rx_in_q_i,
   output logic                                rx_strobe_o,  // Impulse sample ready
   output logic [sounder_pkg::sample_width-1:0] rx_i_o,
   output logic [sounder_pkg::sample_width-1:0] rx_q_o
);

   localparam int ext_width = sounder_pkg::acc_width - sounder_pkg::sample_width;

   logic                                   lfsr_clr;
   logic                                   sample;
   logic                                   last;
   logic                                   sweep_end;
   logic                                   step;
   logic                                   chip;
   logic [sounder_pkg::pn_width-1:0]        count;      // Samples so far in sweep
   logic signed [sounder_pkg::acc_width-1:0] in_i, in_q;
   logic signed [sounder_pkg::acc_width-1:0] acc_i, acc_q;
   logic signed [sounder_pkg::acc_width-1:0] sum_i, sum_q;
   logic signed [sounder_pkg::acc_width-1:0] scaled_i, scaled_q;

   assign lfsr_clr  = clr_i || !ena_i;          // Disabled receiver holds seed
   assign sample    = rx_strobe_i && ena_i;
   assign last      = (count == len_i - 1'b1);  // Strobe that completes the sweep
   assign sweep_end = sample && last && !clr_i;

   // Reference held back on the closing strobe, one chip more lag next sweep
   assign step = sample && !last;

   pn_lfsr u_lfsr (
      .clk_i  (clk_i),
      .clr_i  (lfsr_clr),
      .step_i (step),
      .mask_i (mask_i),
      .chip_o (chip)
   );

   assign in_i = {{ext_width{rx_in_i_i[sounder_pkg::sample_width-1]}}, rx_in_i_i};
   assign in_q = {{ext_width{rx_in_q_i[sounder_pkg::sample_width-1]}}, rx_in_q_i};

   // Despread, add on a one chip and subtract on a zero chip
   assign sum_i = chip ? acc_i + in_i : acc_i - in_i;
   assign sum_q = chip ? acc_q + in_q : acc_q - in_q;

   assign scaled_i = sum_i >>> degree_i;  // Divide by roughly the length
   assign scaled_q = sum_q >>> degree_i;

   always_ff @(posedge clk_i) begin
      if (lfsr_clr) begin
         count       <= '0;
         acc_i       <= '0;
         acc_q       <= '0;
         rx_strobe_o <= 1'b0;
      end else begin
         rx_strobe_o <= 1'b0;            // Single-cycle pulse
         if (sample) begin
            if (last) begin
               count       <= '0;
               acc_i       <= '0;        // Fresh sweep
               acc_q       <= '0;
               rx_strobe_o <= 1'b1;
            end else begin
               count <= count + 1'b1;
               acc_i <= sum_i;
               acc_q <= sum_q;
            end
         end
      end
   end

   // Impulse sample register, held until the next sweep ends
   always_ff @(posedge clk_i) begin
      if (sweep_end) begin
         rx_i_o <= scaled_i[sounder_pkg::sample_width-1:0];
         rx_q_o <= scaled_q[sounder_pkg::sample_width-1:0];
      end
   end

endmodule

// File: logic/sounder_tx.sv
// Sounder transmitter
// Emits one PN chip per strobe as antipodal full-scale DAC codes.
// I carries the chip of the strobe, Q the chip of the strobe before
`timescale 1ns/1ps

module sounder_tx (
   input  logic                             clk_i,
   input  logic                             clr_i,
   input  logic                             ena_i,
   input  logic                             strobe_i,  // One chip per strobe
   input  logic [sounder_pkg::pn_width-1:0]  mask_i,
   output logic [sounder_pkg::dac_width-1:0] tx_i_o,
   output logic [sounder_pkg::dac_width-1:0] tx_q_o
);

   logic lfsr_clr;
   logic step;
   logic chip;

   assign lfsr_clr = clr_i || !ena_i;   // Idle transmitter sits on the seed
   assign step     = strobe_i && ena_i;

   pn_lfsr u_lfsr (
      .clk_i  (clk_i),
      .clr_i  (lfsr_clr),
      .step_i (step),
      .mask_i (mask_i),
      .chip_o (chip)
   );

   always_ff @(posedge clk_i) begin
      if (clr_i) begin
         tx_i_o <= '0;
         tx_q_o <= '0;
      end else if (step) begin
         tx_i_o <= chip ? sounder_pkg::dac_pos : sounder_pkg::dac_neg;
         tx_q_o <= tx_i_o;  // One chip behind I
      end
   end

endmodule

// File: logic/sounder_ctrl.sv
// Sounder control block
// Holds the mode and degree registers, clamps the degree to the supported
// range and registers the matching feedback mask and sequence length.
// Board reset and the mode reset bit are merged into one sequence reset
`timescale 1ns/1ps

module sounder_ctrl (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                s_strobe_i,
   input  logic [sounder_pkg::saddr_width-1:0]  saddr_i,
   input  logic [sounder_pkg::sdata_width-1:0]  sdata_i,
   output logic                                seq_rst_o,
   output logic                                tx_ena_o,
   output logic                                rx_ena_o,
   output logic                                loop_o,
   output logic [sounder_pkg::degree_width-1:0] degree_o,
   output logic [sounder_pkg::pn_width-1:0]     mask_o,
   output logic [sounder_pkg::pn_width-1:0]     len_o
);

   sounder_pkg::mode_t                      mode;
   logic [sounder_pkg::degree_width-1:0]    degree_raw;
   logic [sounder_pkg::pn_width:0]          len_full;  // One bit wider for degree 16

   config_reg #(.addr(sounder_pkg::mode_addr), .payload_t(sounder_pkg::mode_t)) u_mode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .s_strobe_i (s_strobe_i),
      .saddr_i    (saddr_i),
      .sdata_i    (sdata_i),
      .value_o    (mode)
   );

   config_reg #(
      .addr      (sounder_pkg::degree_addr),
      .payload_t (logic [sounder_pkg::degree_width-1:0])
   ) u_degree (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .s_strobe_i (s_strobe_i),
      .saddr_i    (saddr_i),
      .sdata_i    (sdata_i),
      .value_o    (degree_raw)
   );

   // Clamp to the table range
   always_comb begin
      if (degree_raw < sounder_pkg::min_degree) begin
         degree_o = sounder_pkg::min_degree;
      end else if (degree_raw > sounder_pkg::max_degree) begin
         degree_o = sounder_pkg::max_degree;
      end else begin
         degree_o = degree_raw;
      end
   end

   assign len_full = ({{sounder_pkg::pn_width{1'b0}}, 1'b1} << degree_o) - 1'b1;  // 2^n - 1

   // Mask and length trail the degree by one cycle
   always_ff @(posedge clk_i) begin
      mask_o <= sounder_pkg::pn_mask_table[degree_o];
      len_o  <= len_full[sounder_pkg::pn_width-1:0];
   end

   assign seq_rst_o = !rst_n_i || mode.reset;  // Board or software restart
   assign tx_ena_o  = mode.transmit;
   assign rx_ena_o  = mode.receive;
   assign loop_o    = mode.loopback;

endmodule

// File: logic/pn_lfsr.sv
// PN sequence generator
// Galois shift register, shifts right and folds the feedback mask in when
// a one drops out of the low end. Restarts from seed 1 on clear
`timescale 1ns/1ps

module pn_lfsr (
   input  logic                            clk_i,
   input  logic                            clr_i,   // Back to seed
   input  logic                            step_i,  // Advance one chip
   input  logic [sounder_pkg::pn_width-1:0] mask_i,
   output logic                            chip_o
);

   logic [sounder_pkg::pn_width-1:0] state;
   logic [sounder_pkg::pn_width-1:0] state_next;

   // Feedback only when the outgoing bit is set
   always_comb begin
      state_next = state >> 1;
      if (state[0]) begin
         state_next = state_next ^ mask_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (clr_i) begin
         state <= sounder_pkg::pn_width'(1);  // Seed
      end else if (step_i) begin
         state <= state_next;
      end
   end

   assign chip_o = state[0];  // Current chip

endmodule

// File: logic/config_reg.sv
// Configuration bus register
// Captures the low bits of the bus data on a write to its own address,
// one instance per board register
`timescale 1ns/1ps

module config_reg #(
   parameter logic [sounder_pkg::saddr_width-1:0] addr = '0,
   parameter type payload_t = logic
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               s_strobe_i,  // Bus write
   input  logic [sounder_pkg::saddr_width-1:0] saddr_i,
   input  logic [sounder_pkg::sdata_width-1:0] sdata_i,
   output payload_t                           value_o
);

   logic hit;

   assign hit = s_strobe_i && (saddr_i == addr);  // Write to this register

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         value_o <= '0;
      end else if (hit) begin
         value_o <= payload_t'(sdata_i[$bits(payload_t)-1:0]);  // Low bits only
      end
   end

endmodule

// File: logic/sounder_pkg.sv
// Channel sounder shared definitions
// Configuration bus layout, register addresses, sample and field widths,
// DAC full-scale codes and the maximal-length PN feedback masks
package sounder_pkg;

   // Configuration bus
   localparam int saddr_width  = 7;
   localparam int sdata_width  = 32;

   localparam logic [saddr_width-1:0] mode_addr   = 7'd64;  // Mode register
   localparam logic [saddr_width-1:0] degree_addr = 7'd65;  // PN degree register

   // Datapath widths
   localparam int dac_width    = 14;   // DAC sample
   localparam int sample_width = 16;   // ADC sample and impulse sample
   localparam int degree_width = 5;
   localparam int pn_width     = 16;   // LFSR state, mask and length
   localparam int acc_width    = 32;   // Correlation accumulator

   // Antipodal chip codes, full scale
   localparam logic signed [dac_width-1:0] dac_pos = 14'sd8191;
   localparam logic signed [dac_width-1:0] dac_neg = -14'sd8191;

   // Supported PN degrees
   localparam logic [degree_width-1:0] min_degree = 5'd2;
   localparam logic [degree_width-1:0] max_degree = 5'd16;

   // Galois feedback masks, bit t-1 set for each polynomial tap t
   localparam logic [pn_width-1:0] pn_mask_table [min_degree:max_degree] = '{
      16'h0003,   // 2: taps 2,1
      16'h0006,   // 3: taps 3,2
      16'h000C,   // 4: taps 4,3
      16'h0014,   // 5: taps 5,3
      16'h0030,   // 6: taps 6,5
      16'h0060,   // 7: taps 7,6
      16'h00B8,   // 8: taps 8,6,5,4
      16'h0110,   // 9: taps 9,5
      16'h0240,   // 10: taps 10,7
      16'h0500,   // 11: taps 11,9
      16'h0829,   // 12: taps 12,6,4,1
      16'h100D,   // 13: taps 13,4,3,1
      16'h2015,   // 14: taps 14,5,3,1
      16'h6000,   // 15: taps 15,14
      16'hD008    // 16: taps 16,15,13,4
   };

   // Mode register, loopback in the top bit
   typedef struct packed {
      logic loopback;  // DAC muted, Tx fed to Rx
      logic receive;   // Correlator enable
      logic transmit;  // PN transmitter enable
      logic reset;     // Sequence restart
   } mode_t;

endpackage
